/* src.f */
+incdir+common
common/objMotionPkg.sv
hdl/apbRegBank.sv
objMotion/jumpProfile.sv
objMotion/objPosGen.sv
hdl/boxPixelHit.sv
hdl/objMotionTop.sv
tests/objMotionTb.sv

/* run.sh */
#!/bin/sh
# build and run the sprite motion testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module objMotionTb -f src.f

simOut=$(./obj_dir/VobjMotionTb)
echo "$simOut"

if echo "$simOut" | grep -qx "All tests passed!"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

/* tests/objMotionTb.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// sprite motion testbench
// APB access, per-frame box and pixel hit checks
//----------------------------
module objMotionTb;
	import objMotionPkg::*;

	// command bits, left is bit 0
	localparam int cmdLeft = 1;
	localparam int cmdRight = 2;
	localparam int cmdUp = 4;
	localparam int cmdDown = 8;
	localparam int cmdDash = 16;
	localparam int cmdJump = 32;
	localparam int cmdRestart = 64;
	localparam int spriteW = 32; // same size in every case
	localparam int spriteH = 32;
	localparam int dispW = 640;
	localparam int dispH = 480; // landing line
	localparam int pixSamples = 64;

	// one row of the case table
	typedef struct packed {
		int startX;
		int startY;
		int gainX;
		int gainY;
		int dash;
		int peak; // climb height
		int jGain; // launch speed
		int jMax;
		int jMin;
		int period;
		int cmd;
		int frames;
	} caseT;

	logic iClk = 1'b0;
	logic arstN;
	logic frameEnd;
	logic [`APB_AW-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_DW-1:0] pwdata;
	logic [`APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [`H_WIDTH-1:0] pixelX;
	logic [`V_WIDTH-1:0] pixelY;
	logic hit;
	objBoxT box;

	caseT caseQ[$];
	string nameQ[$];
	int errCnt = 0;
	int checkCnt = 0;
	int caseErr = 0; // errors in the running test
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCnt = 0;
	int cycleLimit = 0; // set once the table is built
	logic [15:0] lfsrState;

	// reference model state
	int refLeft;
	int refRight;
	int refTop;
	int refUnder;
	bit refActive;
	bit refPeak;
	int refSpeed;
	int refBudget;
	int refCnt;

	objMotionTop dut_i (.*);

	always #4 iClk = ~iClk; // 8 ns period

	// run limit
	always @(posedge iClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleLimit > 0 && cycleCnt >= cycleLimit)
		begin
			$display("run stopped, tests still busy after %0d cycles", cycleCnt);
			$display("Test failures found");
			$finish;
		end
	end

	//----------------------------
	// checks and stimulus helpers
	//----------------------------
	task automatic checkValue(input string sig, input int got, input int exp);
		checkCnt++;
		if (got !== exp)
		begin
			errCnt++;
			caseErr++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, sig, got, exp);
		end
	endtask

	task automatic reportTest(input string name);
		testsRun++;
		if (caseErr != 0)
		begin
			testsFailed++;
		end
		$display("%s: %s, %0d errors", name, (caseErr == 0) ? "ok" : "FAILED", caseErr);
	endtask

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int takeBits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState); // one step per bit
			v = (v << 1) | int'(lfsrState[0]);
		end
		return v;
	endfunction

	function automatic logic [`APB_AW-1:0] wordAddr(input int word);
		return {word[5:0], 2'b00};
	endfunction

	// two 12 bit fields, low half and high half
	function automatic logic [`APB_DW-1:0] packPair(input int lo, input int hi);
		logic [`APB_DW-1:0] w;
		w = '0;
		w[11:0] = lo[11:0];
		w[27:16] = hi[11:0];
		return w;
	endfunction

	function automatic logic [`APB_DW-1:0] packGain(input int gx, input int gy, input int dg,
		input int per);
		logic [`APB_DW-1:0] w;
		w = '0;
		w[3:0] = gx[3:0];
		w[11:8] = gy[3:0];
		w[20:16] = dg[4:0];
		w[29:24] = per[5:0];
		return w;
	endfunction

	function automatic logic [`APB_DW-1:0] packJump(input int pk, input int jg, input int mx,
		input int mn);
		logic [`APB_DW-1:0] w;
		w = '0;
		w[11:0] = pk[11:0];
		w[20:16] = jg[4:0];
		w[25:21] = mx[4:0];
		w[30:26] = mn[4:0];
		return w;
	endfunction

	// setup phase, access phase, then idle
	task automatic apbWrite(input int word, input logic [`APB_DW-1:0] data, output logic err);
		@(posedge iClk);
		paddr <= wordAddr(word);
		pwrite <= 1'b1;
		pwdata <= data;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge iClk);
		penable <= 1'b1;
		@(negedge iClk);
		err = pslverr; // mid access phase
		@(posedge iClk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input int word, output logic [`APB_DW-1:0] data, output logic err);
		@(posedge iClk);
		paddr <= wordAddr(word);
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge iClk);
		penable <= 1'b1;
		@(negedge iClk);
		data = prdata;
		err = pslverr;
		checkValue("pready", int'(pready), 1);
		@(posedge iClk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic regWrite(input int word, input logic [`APB_DW-1:0] data);
		logic err;
		apbWrite(word, data, err);
		checkValue($sformatf("pslverr write reg %0d", word), int'(err), 0);
	endtask

	// one frame, box settled by the negedge after it
	task automatic pulseFrame();
		@(posedge iClk);
		frameEnd <= 1'b1;
		@(posedge iClk);
		frameEnd <= 1'b0;
		@(negedge iClk);
	endtask

	//----------------------------
	// reference model
	//----------------------------
	task automatic loadStartModel(input caseT c);
		refLeft = c.startX;
		refRight = c.startX + spriteW;
		refTop = c.startY;
		refUnder = c.startY + spriteH;
		refActive = 1'b0;
		refPeak = 1'b0;
	endtask

	task automatic stepModel(input caseT c);
		int xStep;
		int dy;
		bit goLeft;
		bit goRight;
		bit goUp;
		bit goDown;
		bit rising;
		bit land;
		goLeft = ((c.cmd & cmdLeft) != 0) && ((c.cmd & cmdRight) == 0);
		goRight = ((c.cmd & cmdRight) != 0) && ((c.cmd & cmdLeft) == 0);
		goUp = ((c.cmd & cmdUp) != 0) && ((c.cmd & cmdDown) == 0);
		goDown = ((c.cmd & cmdDown) != 0) && ((c.cmd & cmdUp) == 0);
		xStep = ((c.cmd & cmdDash) != 0) ? c.dash : c.gainX;
		rising = refActive && !refPeak; // state before this frame
		land = refActive && refPeak && (refUnder + refSpeed > dispH);
		if (goLeft)
		begin
			refLeft -= xStep;
			refRight -= xStep;
		end
		else if (goRight)
		begin
			refLeft += xStep;
			refRight += xStep;
		end
		if (land)
		begin
			refTop = c.startY; // back on the start row
			refUnder = c.startY + spriteH;
		end
		else if (refActive)
		begin
			dy = rising ? -refSpeed : refSpeed; // up/down ignored in the air
			refTop += dy;
			refUnder += dy;
		end
		else if (goUp)
		begin
			refTop -= c.gainY;
			refUnder -= c.gainY;
		end
		else if (goDown)
		begin
			refTop += c.gainY;
			refUnder += c.gainY;
		end
		// jump state for the next frame
		if (land)
		begin
			refActive = 1'b0;
			refPeak = 1'b0;
		end
		else if (!refActive)
		begin
			if ((c.cmd & cmdJump) != 0)
			begin
				refActive = 1'b1;
				refPeak = 1'b0;
				refSpeed = c.jGain;
				refBudget = c.peak;
				refCnt = 0;
			end
		end
		else
		begin
			if (rising)
			begin
				refBudget -= refSpeed;
				refPeak = (refBudget < 0); // climbed past the peak
			end
			if (refCnt == c.period)
			begin
				refCnt = 0;
				if (rising && refSpeed != c.jMin)
				begin
					refSpeed -= 1;
				end
				else if (!rising && refSpeed != c.jMax)
				begin
					refSpeed += 1;
				end
			end
			else
			begin
				refCnt += 1;
			end
		end
	endtask

	//----------------------------
	// tests
	//----------------------------
	task automatic regAccessTest();
		int words[6];
		logic [`APB_DW-1:0] vals[6];
		logic [`APB_DW-1:0] rd;
		logic err;
		int k;
		caseErr = 0;
		words[0] = `REG_CTRL;
		vals[0] = 32'h3A; // restart bit clear
		words[1] = `REG_START;
		vals[1] = packPair(-100, 300);
		words[2] = `REG_SIZE;
		vals[2] = packPair(24, 40);
		words[3] = `REG_DISPLAY;
		vals[3] = packPair(800, 600);
		words[4] = `REG_GAIN;
		vals[4] = packGain(5, 3, 11, 42);
		words[5] = `REG_JUMP;
		vals[5] = packJump(60, 9, 7, 2);
		for (k = 0; k < 6; k++)
		begin
			regWrite(words[k], vals[k]);
		end
		for (k = 0; k < 6; k++)
		begin
			apbRead(words[k], rd, err);
			checkValue($sformatf("prdata reg %0d", words[k]), int'(rd), int'(vals[k]));
			checkValue($sformatf("pslverr read reg %0d", words[k]), int'(err), 0);
		end
		// status words are read only, 9 and 12 are unmapped
		apbWrite(`REG_STAT_X, 32'hFFFF_FFFF, err);
		checkValue("pslverr write STAT_X", int'(err), 1);
		apbWrite(9, 32'h1234, err);
		checkValue("pslverr write reg 9", int'(err), 1);
		apbRead(12, rd, err);
		checkValue("pslverr read reg 12", int'(err), 1);
		apbRead(`REG_STAT_X, rd, err);
		checkValue("STAT_X after reset", int'(rd),
			int'(packPair(`RST_START_X, `RST_START_X + `RST_SIZE_X)));
		apbRead(`REG_STAT_Y, rd, err);
		checkValue("STAT_Y after reset", int'(rd),
			int'(packPair(`RST_START_Y, `RST_START_Y + `RST_SIZE_Y)));
		regWrite(`REG_CTRL, 0);
		reportTest("register access");
	endtask

	task automatic runCase(input int idx);
		caseT c;
		logic [`APB_DW-1:0] rd;
		logic err;
		int f;
		c = caseQ[idx];
		caseErr = 0;
		regWrite(`REG_START, packPair(c.startX, c.startY));
		regWrite(`REG_SIZE, packPair(spriteW, spriteH));
		regWrite(`REG_DISPLAY, packPair(dispW, dispH));
		regWrite(`REG_GAIN, packGain(c.gainX, c.gainY, c.dash, c.period));
		regWrite(`REG_JUMP, packJump(c.peak, c.jGain, c.jMax, c.jMin));
		// restart loads the start box and ends any jump
		regWrite(`REG_CTRL, cmdRestart);
		pulseFrame();
		loadStartModel(c);
		checkValue("box.left after restart", int'(box.left), refLeft);
		checkValue("box.right after restart", int'(box.right), refRight);
		checkValue("box.top after restart", int'(box.top), refTop);
		checkValue("box.under after restart", int'(box.under), refUnder);
		regWrite(`REG_CTRL, c.cmd);
		for (f = 1; f <= c.frames; f++)
		begin
			pulseFrame();
			stepModel(c);
			checkValue($sformatf("box.left frame %0d", f), int'(box.left), refLeft);
			checkValue($sformatf("box.top frame %0d", f), int'(box.top), refTop);
		end
		apbRead(`REG_STAT_X, rd, err);
		checkValue("STAT_X", int'(rd), int'(packPair(refLeft, refRight)));
		apbRead(`REG_STAT_Y, rd, err);
		checkValue("STAT_Y", int'(rd), int'(packPair(refTop, refUnder)));
		regWrite(`REG_CTRL, 0);
		reportTest($sformatf("case %0d %s", idx, nameQ[idx]));
	endtask

	// stream pixels around the box, one per clock
	task automatic pixelTest();
		int i;
		int x;
		int y;
		int expHit;
		int prevX;
		int prevY;
		int prevHit;
		int baseX;
		int baseY;
		caseErr = 0;
		baseX = (int'(box.left) > 8) ? int'(box.left) - 8 : 0;
		baseY = (int'(box.top) > 8) ? int'(box.top) - 8 : 0;
		prevX = 0;
		prevY = 0;
		prevHit = 0;
		for (i = 0; i <= pixSamples; i++)
		begin
			x = baseX + takeBits(6);
			y = baseY + takeBits(6);
			expHit = (x >= int'(box.left) && x < int'(box.right) &&
				y >= int'(box.top) && y < int'(box.under)) ? 1 : 0;
			@(posedge iClk);
			pixelX <= x[`H_WIDTH-1:0];
			pixelY <= y[`V_WIDTH-1:0];
			@(negedge iClk);
			if (i > 0)
			begin
				checkValue($sformatf("hit at %0d,%0d", prevX, prevY), int'(hit), prevHit);
			end
			prevX = x;
			prevY = y;
			prevHit = expHit;
		end
		reportTest("pixel hit");
	endtask

	task automatic addCase(input string name, input int sx, input int sy, input int gx,
		input int gy, input int dg, input int pk, input int jg, input int jmax, input int jmin,
		input int per, input int cmd, input int frames);
		caseT c;
		c = '{sx, sy, gx, gy, dg, pk, jg, jmax, jmin, per, cmd, frames};
		caseQ.push_back(c);
		nameQ.push_back(name);
	endtask

	task automatic buildTable();
		//       name            sx   sy  gx gy dg  pk jg mx mn per cmd  frames
		addCase("walk right", 100, 448, 2, 1, 7, 40, 8, 7, 1, 1, cmdRight, 10);
		addCase("walk left", 300, 448, 3, 1, 7, 40, 8, 7, 1, 1, cmdLeft, 12);
		addCase("left and right", 200, 400, 3, 2, 7, 40, 8, 7, 1, 1, cmdLeft | cmdRight, 6);
		addCase("dash right", 50, 448, 2, 1, 7, 40, 8, 7, 1, 1, cmdRight | cmdDash, 8);
		addCase("dash left", 400, 448, 2, 1, 5, 40, 8, 7, 1, 1, cmdLeft | cmdDash, 6);
		addCase("step up", 320, 300, 1, 3, 7, 40, 8, 7, 1, 1, cmdUp, 9);
		addCase("step down", 320, 200, 1, 2, 7, 40, 8, 7, 1, 1, cmdDown, 9);
		addCase("jump", 100, 448, 1, 1, 7, 40, 8, 7, 1, 1, cmdJump, 40);
		addCase("jump, up in air", 100, 448, 1, 2, 7, 20, 6, 5, 2, 0,
			cmdJump | cmdUp | cmdRight, 30);
		addCase("start above screen", 200, -10, 1, 3, 7, 40, 8, 7, 1, 1, cmdDown, 5);
		addCase("start left of screen", -12, 100, 1, 1, 7, 40, 8, 7, 1, 1, cmdLeft, 4);
	endtask

	//----------------------------
	// main sequence
	//----------------------------
	initial
	begin
		int i;
		int totalFrames;
		arstN = 1'b0;
		frameEnd = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		pixelX = '0;
		pixelY = '0;
		lfsrState = 16'd5319;
		buildTable();
		totalFrames = 0;
		foreach (caseQ[k])
		begin
			totalFrames += caseQ[k].frames;
		end
		// about 4 cycles per frame, 50 per case of APB traffic, doubled
		cycleLimit = 2 * (totalFrames * 4 + caseQ.size() * 50 + pixSamples * 2 + 200);
		repeat (10) @(posedge iClk);
		arstN <= 1'b1;
		@(posedge iClk);
		regAccessTest();
		for (i = 0; i < caseQ.size(); i++)
		begin
			runCase(i);
		end
		pixelTest(); // box partly off screen from the last case
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			testsRun, testsFailed, checkCnt, errCnt);
		if (errCnt == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* hdl/objMotionTop.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// sprite motion top
// APB regs, jump profile, position and pixel hit
//----------------------------
module objMotionTop
(
	input logic iClk,
	input logic arstN,
	input logic frameEnd, // from video timing
	// APB slave
	input logic [`APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_DW-1:0] pwdata,
	output logic [`APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	// raster
	input logic [`H_WIDTH-1:0] pixelX,
	input logic [`V_WIDTH-1:0] pixelY,
	output logic hit,
	output objMotionPkg::objBoxT box // current box
);
	import objMotionPkg::*;

	objCfgT cfg;
	moveCmdT cmd;
	jumpStateT jump;

	// register side
	apbRegBank regBank_i (.*);

	// motion core, both step on frameEnd
	jumpProfile jumpProfile_i (.*);
	objPosGen posGen_i (.*);

	// raster side
	boxPixelHit pixelHit_i (.*);

endmodule

/* hdl/boxPixelHit.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// box pixel hit
// registered inside-box test for the raster pixel
//----------------------------
module boxPixelHit
(
	input logic iClk,
	input logic arstN,
	input logic [`H_WIDTH-1:0] pixelX,
	input logic [`V_WIDTH-1:0] pixelY,
	input objMotionPkg::objBoxT box,
	output logic hit
);

	logic signed [`H_WIDTH:0] px; // raster is never negative
	logic signed [`V_WIDTH:0] py;
	logic inX;
	logic inY;

	assign px = $signed({1'b0, pixelX});
	assign py = $signed({1'b0, pixelY});

	// left/top inclusive, right/under exclusive
	assign inX = (px >= box.left) && (px < box.right);
	assign inY = (py >= box.top) && (py < box.under);

	// one stage, a pixel per clock
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hit <= 1'b0;
		end
		else
		begin
			hit <= inX & inY;
		end
	end

endmodule

/* objMotion/objPosGen.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// object position generator
// per-frame box update for walk, dash and jump
//----------------------------
module objPosGen
(
	input logic iClk,
	input logic arstN,
	input logic frameEnd,
	input objMotionPkg::objCfgT cfg,
	input objMotionPkg::moveCmdT cmd,
	input objMotionPkg::jumpStateT jump,
	output objMotionPkg::objBoxT box
);
	import objMotionPkg::*;

	// start box, size extended by a zero sign bit
	function automatic objBoxT startBox(input objCfgT c);
		objBoxT b;
		b.left = c.startX;
		b.right = c.startX + $signed({1'b0, c.sizeX});
		b.top = c.startY;
		b.under = c.startY + $signed({1'b0, c.sizeY});
		return b;
	endfunction

	localparam objBoxT boxRst = startBox(cfgRst);

	objBoxT initBox; // start box from the live config
	logic signed [`H_WIDTH:0] xStep;
	logic signed [`V_WIDTH:0] yStep;
	logic signed [`V_WIDTH:0] dispH;
	logic signed [`V_WIDTH:0] underNext;
	logic moveLeft;
	logic moveRight;
	logic moveUp;
	logic moveDown;
	logic landing;

	assign initBox = startBox(cfg);

	//----------------------------
	// step selection
	//----------------------------
	assign xStep = cmd.dash ? $signed(cfg.dashGain) : $signed(cfg.basicGainX);
	assign yStep = $signed(cfg.basicGainY);

	// one direction only, both or none holds still
	assign moveLeft = cmd.left & ~cmd.right;
	assign moveRight = cmd.right & ~cmd.left;
	assign moveUp = cmd.up & ~cmd.down;
	assign moveDown = cmd.down & ~cmd.up;

	// same floor test as the jump profile
	assign dispH = $signed({1'b0, cfg.dispH});
	assign underNext = box.under + jump.speed;
	assign landing = jump.active & jump.peakPassed & (underNext > dispH);

	//----------------------------
	// box registers
	//----------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			box <= boxRst;
		end
		else if (frameEnd)
		begin
			if (cmd.restart)
			begin
				box <= initBox; // whole start box
			end
			else
			begin
				// horizontal
				if (moveLeft)
				begin
					box.left <= box.left - xStep;
					box.right <= box.right - xStep;
				end
				else if (moveRight)
				begin
					box.left <= box.left + xStep;
					box.right <= box.right + xStep;
				end

				// vertical, up/down ignored in the air
				if (landing)
				begin
					box.top <= initBox.top; // back to start row
					box.under <= initBox.under;
				end
				else if (jump.active && !jump.peakPassed)
				begin
					box.top <= box.top - jump.speed; // rising
					box.under <= box.under - jump.speed;
				end
				else if (jump.active)
				begin
					box.top <= box.top + jump.speed; // falling
					box.under <= box.under + jump.speed;
				end
				else if (moveUp)
				begin
					box.top <= box.top - yStep;
					box.under <= box.under - yStep;
				end
				else if (moveDown)
				begin
					box.top <= box.top + yStep;
					box.under <= box.under + yStep;
				end
			end
		end
	end

endmodule

/* objMotion/jumpProfile.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// jump profile
// jump state and vertical speed, stepped once per frame
//----------------------------
module jumpProfile
(
	input logic iClk,
	input logic arstN,
	input logic frameEnd,
	input objMotionPkg::objCfgT cfg,
	input objMotionPkg::moveCmdT cmd,
	input objMotionPkg::objBoxT box, // for the landing test
	output objMotionPkg::jumpStateT jump
);

	logic signed [`V_WIDTH:0] budget; // height left to climb
	logic signed [`V_WIDTH:0] budgetNext;
	logic [5:0] updCnt; // frames since last speed step
	logic updTick;
	logic signed [`V_WIDTH:0] initSpeed;
	logic signed [`V_WIDTH:0] minSpeed;
	logic signed [`V_WIDTH:0] maxSpeed;
	logic signed [`V_WIDTH:0] dispH;
	logic signed [`V_WIDTH:0] underNext;
	logic landing;

	// sign extend the narrow limits to speed width
	assign initSpeed = $signed(cfg.jumpGain);
	assign minSpeed = $signed(cfg.jyroMin);
	assign maxSpeed = $signed(cfg.jyroMax);
	assign dispH = $signed({1'b0, cfg.dispH});

	assign budgetNext = budget - jump.speed;
	assign updTick = (updCnt == cfg.jumpPeriod);

	// only while falling, the start row sits on the floor
	assign underNext = box.under + jump.speed;
	assign landing = jump.active & jump.peakPassed & (underNext > dispH);

	//----------------------------
	// jump FSM and speed
	//----------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			jump <= '0;
			budget <= '0;
			updCnt <= '0;
		end
		else if (frameEnd)
		begin
			if (cmd.restart || landing)
			begin
				jump.active <= 1'b0; // back on the ground
				jump.peakPassed <= 1'b0;
			end
			else if (!jump.active)
			begin
				if (cmd.jump)
				begin
					jump.active <= 1'b1; // launch
					jump.peakPassed <= 1'b0;
					jump.speed <= initSpeed;
					budget <= cfg.jumpPeak;
					updCnt <= '0;
				end
			end
			else
			begin
				// climb until the budget goes negative
				if (!jump.peakPassed)
				begin
					budget <= budgetNext;
					jump.peakPassed <= budgetNext[`V_WIDTH];
				end

				if (updTick)
				begin
					updCnt <= '0;
					if (!jump.peakPassed)
					begin
						if (jump.speed != minSpeed)
						begin
							jump.speed <= jump.speed - 1; // slow the rise
						end
					end
					else if (jump.speed != maxSpeed)
					begin
						jump.speed <= jump.speed + 1; // speed up the fall
					end
				end
				else
				begin
					updCnt <= updCnt + 1'b1;
				end
			end
		end
	end

endmodule

/* hdl/apbRegBank.sv */
`timescale 1ns/10ps
`include "objMotion_settings.svh"
//----------------------------
// APB register bank
// sprite config, move commands and box status words
//----------------------------
module apbRegBank
(
	input logic iClk,
	input logic arstN,
	input logic [`APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_DW-1:0] pwdata,
	output logic [`APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic frameEnd, // consumes restart
	output objMotionPkg::objCfgT cfg,
	output objMotionPkg::moveCmdT cmd,
	input objMotionPkg::objBoxT box
);
	import objMotionPkg::*;

	logic [`APB_AW-3:0] wordIdx;
	logic access; // APB access phase
	logic mapped;
	logic readOnly;
	logic wrEn;
	logic [`APB_DW-1:0] rdWord;

	assign wordIdx = paddr[`APB_AW-1:2];
	assign access = psel & penable;
	assign readOnly = (wordIdx == `REG_STAT_X) || (wordIdx == `REG_STAT_Y);
	assign wrEn = access & pwrite & mapped & ~readOnly;

	assign pready = 1'b1; // no wait states
	assign pslverr = access & (~mapped | (pwrite & readOnly));
	assign prdata = access ? rdWord : '0;

	//----------------------------
	// read mux and map decode
	//----------------------------
	always_comb
	begin
		rdWord = '0;
		mapped = (paddr[1:0] == 2'b00); // word aligned only
		case (wordIdx)
			`REG_CTRL: rdWord[$bits(moveCmdT)-1:0] = cmd;
			`REG_START:
			begin
				rdWord[`H_WIDTH:0] = cfg.startX;
				rdWord[16+:`V_WIDTH+1] = cfg.startY;
			end
			`REG_SIZE:
			begin
				rdWord[`H_WIDTH-1:0] = cfg.sizeX;
				rdWord[16+:`V_WIDTH] = cfg.sizeY;
			end
			`REG_DISPLAY:
			begin
				rdWord[`H_WIDTH-1:0] = cfg.dispW;
				rdWord[16+:`V_WIDTH] = cfg.dispH;
			end
			`REG_GAIN:
			begin
				rdWord[`BASIC_GAIN_WIDTH:0] = cfg.basicGainX;
				rdWord[8+:`BASIC_GAIN_WIDTH+1] = cfg.basicGainY;
				rdWord[16+:`DASH_GAIN_WIDTH+1] = cfg.dashGain;
				rdWord[24+:6] = cfg.jumpPeriod;
			end
			`REG_JUMP:
			begin
				rdWord[`V_WIDTH:0] = cfg.jumpPeak;
				rdWord[16+:`JYRO_WIDTH+1] = cfg.jumpGain;
				rdWord[21+:`JYRO_WIDTH+1] = cfg.jyroMax;
				rdWord[26+:`JYRO_WIDTH+1] = cfg.jyroMin;
			end
			`REG_STAT_X:
			begin
				rdWord[`H_WIDTH:0] = box.left; // live box
				rdWord[16+:`H_WIDTH+1] = box.right;
			end
			`REG_STAT_Y:
			begin
				rdWord[`V_WIDTH:0] = box.top;
				rdWord[16+:`V_WIDTH+1] = box.under;
			end
			default: mapped = 1'b0;
		endcase
	end

	//----------------------------
	// configuration registers
	//----------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cfg <= cfgRst;
		end
		else if (wrEn)
		begin
			case (wordIdx)
				`REG_START:
				begin
					cfg.startX <= pwdata[`H_WIDTH:0];
					cfg.startY <= pwdata[16+:`V_WIDTH+1];
				end
				`REG_SIZE:
				begin
					cfg.sizeX <= pwdata[`H_WIDTH-1:0];
					cfg.sizeY <= pwdata[16+:`V_WIDTH];
				end
				`REG_DISPLAY:
				begin
					cfg.dispW <= pwdata[`H_WIDTH-1:0];
					cfg.dispH <= pwdata[16+:`V_WIDTH];
				end
				`REG_GAIN:
				begin
					cfg.basicGainX <= pwdata[`BASIC_GAIN_WIDTH:0];
					cfg.basicGainY <= pwdata[8+:`BASIC_GAIN_WIDTH+1];
					cfg.dashGain <= pwdata[16+:`DASH_GAIN_WIDTH+1];
					cfg.jumpPeriod <= pwdata[24+:6];
				end
				`REG_JUMP:
				begin
					cfg.jumpPeak <= pwdata[`V_WIDTH:0];
					cfg.jumpGain <= pwdata[16+:`JYRO_WIDTH+1];
					cfg.jyroMax <= pwdata[21+:`JYRO_WIDTH+1];
					cfg.jyroMin <= pwdata[26+:`JYRO_WIDTH+1];
				end
				default: ; // ctrl has its own register
			endcase
		end
	end

	// command bits, a new write beats the restart clear
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cmd <= '0;
		end
		else if (wrEn && (wordIdx == `REG_CTRL))
		begin
			cmd <= moveCmdT'(pwdata[$bits(moveCmdT)-1:0]);
		end
		else if (frameEnd)
		begin
			cmd.restart <= 1'b0; // used by this frame
		end
	end

endmodule

/* common/objMotionPkg.sv */
//----------------------------
// sprite motion shared types
//----------------------------
`include "objMotion_settings.svh"

package objMotionPkg;

	//----------------------------
	// frame-static configuration
	//----------------------------
	typedef struct packed {
		logic [`H_WIDTH-1:0] dispW; // screen width
		logic [`V_WIDTH-1:0] dispH; // screen height, landing line
		logic signed [`H_WIDTH:0] startX;
		logic signed [`V_WIDTH:0] startY;
		logic [`H_WIDTH-1:0] sizeX; // never negative
		logic [`V_WIDTH-1:0] sizeY;
		logic signed [`BASIC_GAIN_WIDTH:0] basicGainX;
		logic signed [`BASIC_GAIN_WIDTH:0] basicGainY;
		logic signed [`DASH_GAIN_WIDTH:0] dashGain;
		logic signed [`V_WIDTH:0] jumpPeak; // climb height
		logic signed [`JYRO_WIDTH:0] jumpGain; // launch speed
		logic signed [`JYRO_WIDTH:0] jyroMax; // fall speed cap
		logic signed [`JYRO_WIDTH:0] jyroMin; // rise speed floor
		logic [5:0] jumpPeriod; // frames per speed step, minus one
	} objCfgT;

	// movement commands, left is bit 0
	typedef struct packed {
		logic restart; // self-clearing
		logic jump;
		logic dash;
		logic down;
		logic up;
		logic right;
		logic left;
	} moveCmdT;

	// bounding box, right and under are exclusive
	typedef struct packed {
		logic signed [`H_WIDTH:0] left;
		logic signed [`H_WIDTH:0] right;
		logic signed [`V_WIDTH:0] top;
		logic signed [`V_WIDTH:0] under;
	} objBoxT;

	typedef struct packed {
		logic active;
		logic peakPassed; // falling half
		logic signed [`V_WIDTH:0] speed; // pixels per frame
	} jumpStateT;

	// reset configuration, no motion until software sets gains
	localparam objCfgT cfgRst = '{
		dispW: `RST_DISP_W,
		dispH: `RST_DISP_H,
		startX: `RST_START_X,
		startY: `RST_START_Y,
		sizeX: `RST_SIZE_X,
		sizeY: `RST_SIZE_Y,
		default: '0
	};

endpackage

/* common/objMotion_settings.svh */
//----------------------------
// sprite motion settings
// coordinate and gain widths, register map, reset geometry
//----------------------------
`ifndef OBJ_MOTION_SETTINGS_SVH
`define OBJ_MOTION_SETTINGS_SVH

// screen coordinate widths, positions are one bit wider and signed
`define H_WIDTH 11
`define V_WIDTH 11

// step and jump speed widths, stored one bit wider and signed
`define BASIC_GAIN_WIDTH 3
`define DASH_GAIN_WIDTH 4
`define JYRO_WIDTH 4

// APB bus
`define APB_AW 8
`define APB_DW 32

// word offsets
`define REG_CTRL 0
`define REG_START 1
`define REG_SIZE 2
`define REG_DISPLAY 3
`define REG_GAIN 4
`define REG_JUMP 5
`define REG_STAT_X 6 // left / right, read only
`define REG_STAT_Y 7 // top / under, read only

// power-up geometry, gains come up zero
`define RST_DISP_W 640
`define RST_DISP_H 480
`define RST_START_X 0
`define RST_START_Y 448
`define RST_SIZE_X 32
`define RST_SIZE_Y 32

`endif
